//--- parser.f
+incdir+tests
hdl/parser_pkg.sv
hdl/hdr_capture.sv
hdl/field_extract.sv
hdl/act_table.sv
hdl/act_cfg.sv
hdl/phv_assemble.sv
hdl/parser_top.sv
tests/parser_tb.sv

//--- Bender.yml
package:
  name: parser

sources:
  - hdl/parser_pkg.sv
  - hdl/hdr_capture.sv
  - hdl/field_extract.sv
  - hdl/act_table.sv
  - hdl/act_cfg.sv
  - hdl/phv_assemble.sv
  - hdl/parser_top.sv
  - target: test
    include_dirs:
      - tests
    files:
      - tests/parser_tb.sv

//--- tests/parser_tb_stim.svh
task automatic load_table();
    // actions as (byte offset, type, container index), action 0 first
    // two-beat header, all types, offsets across the beat boundary
    ent_lib[0] = {make_action(60, 3, 0), make_action(62, 2, 1), make_action(64, 1, 2),
                  make_action(66, 3, 3), make_action(70, 2, 4), make_action(0, 1, 0),
                  make_action(14, 2, 7), make_action(125, 3, 5), make_action(3, 0, 6),
                  make_action(127, 1, 6)};
    // single beat, offsets 64 and above read zero
    ent_lib[1] = {make_action(64, 3, 1), make_action(80, 2, 2), make_action(100, 1, 3),
                  make_action(10, 3, 0), make_action(20, 2, 0), make_action(30, 1, 0),
                  make_action(0, 0, 0), make_action(0, 0, 0), make_action(0, 0, 0),
                  make_action(0, 0, 0)};
    // actions 4 and 9 override 0 and 1
    ent_lib[2] = {make_action(8, 2, 5), make_action(12, 1, 1), make_action(2, 3, 7),
                  make_action(0, 0, 0), make_action(40, 2, 5), make_action(90, 3, 2),
                  make_action(16, 1, 4), make_action(0, 0, 0), make_action(24, 2, 0),
                  make_action(50, 1, 1)};
    ent_lib[3] = {make_action(8, 2, 5), make_action(0, 0, 0), make_action(0, 0, 0),
                  make_action(0, 0, 0), make_action(0, 0, 0), make_action(33, 3, 2),
                  make_action(0, 0, 0), make_action(0, 0, 0), make_action(0, 0, 0),
                  make_action(0, 0, 0)};

    // kind, table index, vlan id, beats, flag, mod id, library entry, forwarded
    add_step(k_cfg, 2, 12'h000, 3, 16'hf2f1, 3'd0, 0, 1'b0);
    add_step(k_cfg, 9, 12'h000, 1, 16'hf2f1, 3'd0, 3, 1'b0);
    add_step(k_fwd, 2, 12'h000, 2, 16'h1234, 3'd0, 0, 1'b1);
    add_step(k_fwd, 2, 12'h000, 3, 16'hf2f1, 3'd1, 0, 1'b1);
    add_step(k_data, 0, 12'ha2c, 2, 16'h0000, 3'd0, 0, 1'b0);
    add_step(k_data, 0, 12'h135, 1, 16'h0000, 3'd0, 0, 1'b0);
    add_step(k_data, 0, 12'h347, 2, 16'h0000, 3'd0, 0, 1'b0);
    add_step(k_data, 0, 12'h397, 2, 16'h0000, 3'd0, 0, 1'b0);
    // entry never written
    add_step(k_data, 0, 12'h5f1, 1, 16'h0000, 3'd0, 0, 1'b0);
endtask

//--- tests/parser_tb.sv
`timescale 1ns/1ps

module parser_tb;
    import parser_pkg::*;

    localparam int max_steps = 16;
    localparam int k_cfg     = 0;
    localparam int k_fwd     = 1;
    localparam int k_data    = 2;
    // phv layout, lsb first: vlan id, 2B, 4B, 6B containers
    localparam int off2 = 12;
    localparam int off4 = off2 + 8 * 16;
    localparam int off6 = off4 + 8 * 32;

    logic             axis_clk;
    logic             aresetn;
    logic [511:0]     s_axis_tdata_i;
    logic             s_axis_tvalid_i;
    logic             s_axis_tlast_i;
    logic             phv_valid_o;
    logic [779:0]     phv_o;
    logic [511:0]     c_s_axis_tdata_i;
    logic             c_s_axis_tvalid_i;
    logic             c_s_axis_tlast_i;
    logic [511:0]     c_m_axis_tdata_o;
    logic             c_m_axis_tvalid_o;
    logic             c_m_axis_tlast_o;

    logic [31:0]      lfsr_q;
    int               cyc;
    int               cyc_limit;
    int               errors;
    int               step_errs;
    int               num_steps;
    int               num_passed;
    int               st_kind  [max_steps];
    int               st_addr  [max_steps];
    logic [11:0]      st_vlan  [max_steps];
    int               st_beats [max_steps];
    logic [15:0]      st_flag  [max_steps];
    logic [2:0]       st_mod   [max_steps];
    int               st_ent   [max_steps];
    logic             st_fwd   [max_steps];
    logic [159:0]     ent_lib  [4];
    logic [159:0]     tbl_ref  [16];

    parser_top UUT (
        .axis_clk          (axis_clk),
        .aresetn           (aresetn),
        .s_axis_tdata_i    (s_axis_tdata_i),
        .s_axis_tvalid_i   (s_axis_tvalid_i),
        .s_axis_tlast_i    (s_axis_tlast_i),
        .phv_valid_o       (phv_valid_o),
        .phv_o             (phv_o),
        .c_s_axis_tdata_i  (c_s_axis_tdata_i),
        .c_s_axis_tvalid_i (c_s_axis_tvalid_i),
        .c_s_axis_tlast_i  (c_s_axis_tlast_i),
        .c_m_axis_tdata_o  (c_m_axis_tdata_o),
        .c_m_axis_tvalid_o (c_m_axis_tvalid_o),
        .c_m_axis_tlast_o  (c_m_axis_tlast_o)
    );

    initial begin
        axis_clk = 1'b0;
        forever #4 axis_clk = ~axis_clk;
    end

    always @(posedge axis_clk) begin
        cyc <= cyc + 1;
        if (cyc_limit > 0 && cyc >= cyc_limit) begin
            $display("timeout: test did not finish within %0d cycles", cyc_limit);
            $display("TB FAILED");
            $finish;
        end
    end

    // galois form, taps for x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    task automatic fill_random(output logic [511:0] beat);
        for (int i = 0; i < 512; i++) begin
            beat[i] = lfsr_q[0];
            lfsr_q  = lfsr_step(lfsr_q);
        end
    endtask

    function automatic logic [15:0] make_action(input logic [6:0] off, input logic [1:0] typ,
                                                input logic [2:0] idx);
        return {3'b000, off, typ, idx, 1'b0};
    endfunction

    task automatic add_step(input int kind, input int addr, input logic [11:0] vlan,
                            input int beats, input logic [15:0] flag, input logic [2:0] mod,
                            input int ent, input logic fwd);
        st_kind[num_steps]  = kind;
        st_addr[num_steps]  = addr;
        st_vlan[num_steps]  = vlan;
        st_beats[num_steps] = beats;
        st_flag[num_steps]  = flag;
        st_mod[num_steps]   = mod;
        st_ent[num_steps]   = ent;
        st_fwd[num_steps]   = fwd;
        num_steps++;
    endtask

    function automatic string kind_name(input int k);
        if (k == k_cfg) return "config write";
        if (k == k_fwd) return "foreign control packet";
        return "data packet";
    endfunction

    task automatic check_value(input string what, input logic [1023:0] got,
                               input logic [1023:0] exp);
        if (got !== exp) begin
            $display("ERROR at %0t ns: %s: got %0h, expected %0h", $time, what, got, exp);
            errors++;
            step_errs++;
        end
    endtask

    `include "parser_tb_stim.svh"

    // expected phv from the table entry and the captured header
    task automatic model_phv(input logic [159:0] entry, input logic [1023:0] hdr,
                             input logic [11:0] vlan, output logic [779:0] exp);
        logic [15:0] a;
        logic [47:0] v;
        logic [47:0] c6 [8];
        logic [31:0] c4 [8];
        logic [15:0] c2 [8];
        int          off;
        int          nb;
        int          ix;
        for (int i = 0; i < 8; i++) begin
            c6[i] = '0;
            c4[i] = '0;
            c2[i] = '0;
        end
        for (int k = 0; k < 10; k++) begin
            a   = entry[159 - 16*k -: 16];
            off = a[12:6];
            nb  = 2 * a[5:4];
            ix  = a[3:1];
            v   = '0;
            // byte at the offset goes to the top, bytes past the buffer read zero
            for (int b = 0; b < nb; b++) begin
                if (off + b < 128) v[8*(nb - 1 - b) +: 8] = hdr[8*(off + b) +: 8];
            end
            if (nb == 2) c2[ix] = v[15:0];
            if (nb == 4) c4[ix] = v[31:0];
            if (nb == 6) c6[ix] = v;
        end
        exp = '0;
        for (int i = 7; i >= 0; i--) exp = (exp << 48) | c6[i];
        for (int i = 7; i >= 0; i--) exp = (exp << 32) | c4[i];
        for (int i = 7; i >= 0; i--) exp = (exp << 16) | c2[i];
        exp = (exp << 12) | vlan;
    endtask

    task automatic check_forward(input logic fwd, input logic [511:0] beat, input logic last);
        check_value("c_m_axis_tvalid_o", c_m_axis_tvalid_o, fwd);
        if (fwd) begin
            check_value("c_m_axis_tdata_o", c_m_axis_tdata_o, beat);
            check_value("c_m_axis_tlast_o", c_m_axis_tlast_o, last);
        end
    endtask

    task automatic run_ctl_step(input int s);
        logic [511:0] beat [4];
        int           n;
        logic [159:0] e;
        n = (st_kind[s] == k_cfg) ? st_beats[s] + 1 : st_beats[s];
        for (int j = 0; j < n; j++) begin
            fill_random(beat[j]);
            if (j == 0 || st_kind[s] == k_fwd) begin
                beat[j][ctl_flag_lsb +: 16] = st_flag[s];
                beat[j][ctl_mod_lsb +: 3]   = st_mod[s];
                beat[j][ctl_idx_lsb +: 8]   = st_addr[s];
            end else begin
                e = ent_lib[st_ent[s] + j - 1];
                for (int b = 0; b < 20; b++) beat[j][8*b +: 8] = e[159 - 8*b -: 8];
                tbl_ref[(st_addr[s] + j - 1) & 15] = e;
            end
        end
        for (int j = 0; j < n; j++) begin
            @(posedge axis_clk);
            c_s_axis_tdata_i  <= beat[j];
            c_s_axis_tvalid_i <= 1'b1;
            c_s_axis_tlast_i  <= (j == n - 1);
            @(negedge axis_clk);
            if (j > 0) check_forward(st_fwd[s], beat[j - 1], 1'b0);
        end
        @(posedge axis_clk);
        c_s_axis_tvalid_i <= 1'b0;
        c_s_axis_tlast_i  <= 1'b0;
        @(negedge axis_clk);
        check_forward(st_fwd[s], beat[n - 1], 1'b1);
    endtask

    task automatic run_data_step(input int s);
        logic [511:0] b0;
        logic [511:0] b1;
        logic [779:0] exp;
        int           c0;
        fill_random(b0);
        b0[116 +: 12] = st_vlan[s];
        b1 = '0;
        if (st_beats[s] == 2) fill_random(b1);
        model_phv(tbl_ref[st_vlan[s][7:4]], {b1, b0}, st_vlan[s], exp);
        @(posedge axis_clk);
        c0 = cyc;
        s_axis_tdata_i  <= b0;
        s_axis_tvalid_i <= 1'b1;
        s_axis_tlast_i  <= (st_beats[s] == 1);
        if (st_beats[s] == 2) begin
            @(posedge axis_clk);
            s_axis_tdata_i <= b1;
            s_axis_tlast_i <= 1'b1;
        end
        @(posedge axis_clk);
        s_axis_tvalid_i <= 1'b0;
        s_axis_tlast_i  <= 1'b0;
        @(negedge axis_clk);
        // first beat edge plus three, then one cycle of valid
        while (!phv_valid_o && cyc <= c0 + 8) begin
            @(negedge axis_clk);
        end
        if (!phv_valid_o) begin
            $display("step %0d: phv_valid_o did not rise within 3 cycles of its slot", s);
            errors++;
            step_errs++;
        end else begin
            check_value("phv_valid_o cycle", cyc, c0 + 5);
            for (int i = 0; i < 8; i++) begin
                check_value($sformatf("6B container %0d", i), phv_o[off6 + 48*i +: 48],
                            exp[off6 + 48*i +: 48]);
                check_value($sformatf("4B container %0d", i), phv_o[off4 + 32*i +: 32],
                            exp[off4 + 32*i +: 32]);
                check_value($sformatf("2B container %0d", i), phv_o[off2 + 16*i +: 16],
                            exp[off2 + 16*i +: 16]);
            end
            check_value("vlan id", phv_o[11:0], exp[11:0]);
            @(negedge axis_clk);
            check_value("phv_valid_o after one cycle", phv_valid_o, 1'b0);
        end
    endtask

    initial begin
        aresetn           = 1'b0;
        s_axis_tdata_i    = '0;
        s_axis_tvalid_i   = 1'b0;
        s_axis_tlast_i    = 1'b0;
        c_s_axis_tdata_i  = '0;
        c_s_axis_tvalid_i = 1'b0;
        c_s_axis_tlast_i  = 1'b0;
        lfsr_q     = 32'hb8a4_66e9;
        errors     = 0;
        num_steps  = 0;
        num_passed = 0;
        for (int i = 0; i < 16; i++) tbl_ref[i] = '0;
        load_table();
        cyc_limit = 10 + 200;
        for (int s = 0; s < num_steps; s++) cyc_limit += st_beats[s] + 12;
        repeat (10) @(posedge axis_clk);
        aresetn <= 1'b1;
        repeat (2) @(posedge axis_clk);
        for (int s = 0; s < num_steps; s++) begin
            step_errs = 0;
            if (st_kind[s] == k_data) run_data_step(s);
            else run_ctl_step(s);
            repeat (4) @(posedge axis_clk);
            if (step_errs == 0) begin
                num_passed++;
                $display("step %0d %s: ok", s, kind_name(st_kind[s]));
            end else begin
                $display("step %0d %s: %0d errors", s, kind_name(st_kind[s]), step_errs);
            end
        end
        $display("%0d steps, %0d passed, %0d failed, %0d errors", num_steps, num_passed,
                 num_steps - num_passed, errors);
        if (errors == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule

//--- hdl/parser_top.sv
`timescale 1ns/1ps

module parser_top #(
    parameter logic [2:0] parser_id = 3'd0
) (
    input  logic                           axis_clk,
    input  logic                           aresetn,
    input  logic [parser_pkg::data_w-1:0]  s_axis_tdata_i,
    input  logic                           s_axis_tvalid_i,
    input  logic                           s_axis_tlast_i,
    output logic                           phv_valid_o,
    output logic [parser_pkg::phv_w-1:0]   phv_o,
    input  logic [parser_pkg::data_w-1:0]  c_s_axis_tdata_i,
    input  logic                           c_s_axis_tvalid_i,
    input  logic                           c_s_axis_tlast_i,
    output logic [parser_pkg::data_w-1:0]  c_m_axis_tdata_o,
    output logic                           c_m_axis_tvalid_o,
    output logic                           c_m_axis_tlast_o
);
    import parser_pkg::*;

    logic [hdr_w-1:0]   hdr;
    logic [vlan_w-1:0]  vlan_id;
    logic               hdr_start;
    logic [entry_w-1:0] rd_entry;
    logic               wr_en;
    logic [tbl_aw-1:0]  wr_addr;
    logic [entry_w-1:0] wr_data;
    logic               ext_strobe;
    logic [act_w-1:0]   action [num_act];
    logic [val_w-1:0]   val    [num_act];
    logic [1:0]         typ    [num_act];
    logic [2:0]         idx    [num_act];

    hdr_capture u_capture (
        .axis_clk        (axis_clk),
        .aresetn         (aresetn),
        .s_axis_tdata_i  (s_axis_tdata_i),
        .s_axis_tvalid_i (s_axis_tvalid_i),
        .s_axis_tlast_i  (s_axis_tlast_i),
        .hdr_o           (hdr),
        .vlan_id_o       (vlan_id),
        .hdr_start_o     (hdr_start)
    );

    // entry is indexed by vlan id bits 7 to 4
    act_table u_table (
        .axis_clk  (axis_clk),
        .aresetn   (aresetn),
        .wr_en_i   (wr_en),
        .wr_addr_i (wr_addr),
        .wr_data_i (wr_data),
        .rd_addr_i (vlan_id[4 +: tbl_aw]),
        .rd_data_o (rd_entry)
    );

    act_cfg #(.parser_id(parser_id)) u_cfg (
        .axis_clk          (axis_clk),
        .aresetn           (aresetn),
        .c_s_axis_tdata_i  (c_s_axis_tdata_i),
        .c_s_axis_tvalid_i (c_s_axis_tvalid_i),
        .c_s_axis_tlast_i  (c_s_axis_tlast_i),
        .c_m_axis_tdata_o  (c_m_axis_tdata_o),
        .c_m_axis_tvalid_o (c_m_axis_tvalid_o),
        .c_m_axis_tlast_o  (c_m_axis_tlast_o),
        .wr_en_o           (wr_en),
        .wr_addr_o         (wr_addr),
        .wr_data_o         (wr_data)
    );

    for (genvar k = 0; k < num_act; k++) begin : g_ext
        // action 0 sits at the top of the entry
        assign action[k] = rd_entry[entry_w - 1 - act_w*k -: act_w];

        field_extract u_ext (
            .axis_clk (axis_clk),
            .aresetn  (aresetn),
            .hdr_i    (hdr),
            .action_i (action[k]),
            .strobe_i (ext_strobe),
            .val_o    (val[k]),
            .type_o   (typ[k]),
            .idx_o    (idx[k])
        );
    end

    phv_assemble u_assemble (
        .axis_clk     (axis_clk),
        .aresetn      (aresetn),
        .hdr_start_i  (hdr_start),
        .vlan_id_i    (vlan_id),
        .val_i        (val),
        .type_i       (typ),
        .idx_i        (idx),
        .ext_strobe_o (ext_strobe),
        .phv_valid_o  (phv_valid_o),
        .phv_o        (phv_o)
    );

endmodule

//--- hdl/phv_assemble.sv
`timescale 1ns/1ps

module phv_assemble (
    input  logic                           axis_clk,
    input  logic                           aresetn,
    input  logic                           hdr_start_i,
    input  logic [parser_pkg::vlan_w-1:0]  vlan_id_i,
    input  logic [parser_pkg::val_w-1:0]   val_i  [parser_pkg::num_act],
    input  logic [1:0]                     type_i [parser_pkg::num_act],
    input  logic [2:0]                     idx_i  [parser_pkg::num_act],
    output logic                           ext_strobe_o,
    output logic                           phv_valid_o,
    output logic [parser_pkg::phv_w-1:0]   phv_o
);
    import parser_pkg::*;

    logic [1:0]         state_q;
    logic [cont2_w-1:0] c2_q [num_cont];
    logic [cont4_w-1:0] c4_q [num_cont];
    logic [cont6_w-1:0] c6_q [num_cont];
    logic [val_w-1:0]   swapped [num_act];

    // reverse the low 2*t bytes, so the byte at the offset ends up on top
    function automatic logic [val_w-1:0] swap_bytes(input logic [val_w-1:0] v,
                                                    input logic [1:0] t);
        logic [val_w-1:0] r;
        int               nb;
        r  = '0;
        nb = 2 * t;
        for (int i = 0; i < val_w / 8; i++) begin
            if (i < nb) begin
                r[8*(nb - 1 - i) +: 8] = v[8*i +: 8];
            end
        end
        return r;
    endfunction

    always_ff @(posedge axis_clk or negedge aresetn) begin
        if (!aresetn) begin
            state_q <= ps_idle;
        end else begin
            case (state_q)
                ps_idle:  if (hdr_start_i) state_q <= ps_wait1;
                ps_wait1: state_q <= ps_wait2;
                ps_wait2: state_q <= ps_write;
                default:  state_q <= ps_idle;
            endcase
        end
    end

    assign ext_strobe_o = state_q == ps_wait1;
    assign phv_valid_o  = state_q == ps_write;

    always_comb begin
        for (int k = 0; k < num_act; k++) begin
            swapped[k] = swap_bytes(val_i[k], type_i[k]);
        end
    end

    always_ff @(posedge axis_clk or negedge aresetn) begin
        if (!aresetn) begin
            for (int i = 0; i < num_cont; i++) begin
                c2_q[i] <= '0;
                c4_q[i] <= '0;
                c6_q[i] <= '0;
            end
        end else if (state_q == ps_idle) begin
            // unwritten containers read zero in the next phv
            for (int i = 0; i < num_cont; i++) begin
                c2_q[i] <= '0;
                c4_q[i] <= '0;
                c6_q[i] <= '0;
            end
        end else if (state_q == ps_wait2) begin
            // later actions override earlier ones on the same container
            for (int k = 0; k < num_act; k++) begin
                case (type_i[k])
                    type_2b: c2_q[idx_i[k]] <= swapped[k][cont2_w-1:0];
                    type_4b: c4_q[idx_i[k]] <= swapped[k][cont4_w-1:0];
                    type_6b: c6_q[idx_i[k]] <= swapped[k][cont6_w-1:0];
                    default: ;
                endcase
            end
        end
    end

    for (genvar i = 0; i < num_cont; i++) begin : g_phv
        assign phv_o[vlan_w + cont2_w*i +: cont2_w] = c2_q[i];
        assign phv_o[vlan_w + num_cont*cont2_w + cont4_w*i +: cont4_w] = c4_q[i];
        assign phv_o[vlan_w + num_cont*(cont2_w + cont4_w) + cont6_w*i +: cont6_w] = c6_q[i];
    end

    assign phv_o[vlan_w-1:0] = vlan_id_i;

endmodule

//--- hdl/act_cfg.sv
`timescale 1ns/1ps

module act_cfg #(
    parameter logic [2:0] parser_id = 3'd0
) (
    input  logic                            axis_clk,
    input  logic                            aresetn,
    input  logic [parser_pkg::data_w-1:0]   c_s_axis_tdata_i,
    input  logic                            c_s_axis_tvalid_i,
    input  logic                            c_s_axis_tlast_i,
    output logic [parser_pkg::data_w-1:0]   c_m_axis_tdata_o,
    output logic                            c_m_axis_tvalid_o,
    output logic                            c_m_axis_tlast_o,
    output logic                            wr_en_o,
    output logic [parser_pkg::tbl_aw-1:0]   wr_addr_o,
    output logic [parser_pkg::entry_w-1:0]  wr_data_o
);
    import parser_pkg::*;

    logic [1:0]         state_q;
    logic               cfg_hdr;
    logic [entry_w-1:0] entry;

    assign cfg_hdr = c_s_axis_tvalid_i
                     && c_s_axis_tdata_i[ctl_flag_lsb +: 16] == ctl_flag_val
                     && c_s_axis_tdata_i[ctl_mod_lsb +: 3] == parser_id;

    // byte 0 of the beat becomes the top byte of the entry
    always_comb begin
        for (int i = 0; i < entry_w / 8; i++) begin
            entry[entry_w - 1 - 8*i -: 8] = c_s_axis_tdata_i[8*i +: 8];
        end
    end

    always_ff @(posedge axis_clk or negedge aresetn) begin
        if (!aresetn) begin
            state_q           <= cs_idle;
            c_m_axis_tvalid_o <= 1'b0;
            c_m_axis_tlast_o  <= 1'b0;
            wr_en_o           <= 1'b0;
            wr_addr_o         <= '0;
        end else begin
            wr_en_o           <= 1'b0;
            c_m_axis_tvalid_o <= 1'b0;
            c_m_axis_tlast_o  <= 1'b0;
            case (state_q)
                cs_idle: begin
                    if (cfg_hdr) begin
                        wr_addr_o <= c_s_axis_tdata_i[ctl_idx_lsb +: tbl_aw];
                        state_q   <= cs_first;
                    end else begin
                        c_m_axis_tvalid_o <= c_s_axis_tvalid_i;
                        c_m_axis_tlast_o  <= c_s_axis_tlast_i;
                    end
                end
                cs_first, cs_next: begin
                    if (c_s_axis_tvalid_i) begin
                        wr_en_o <= 1'b1;
                        // first entry goes to the header index as loaded
                        if (state_q == cs_next) begin
                            wr_addr_o <= wr_addr_o + 1'b1;
                        end
                        state_q <= c_s_axis_tlast_i ? cs_idle : cs_next;
                    end
                end
                default: state_q <= cs_idle;
            endcase
        end
    end

    always_ff @(posedge axis_clk) begin
        c_m_axis_tdata_o <= c_s_axis_tdata_i;
        wr_data_o        <= entry;
    end

endmodule

//--- hdl/act_table.sv
`timescale 1ns/1ps

module act_table (
    input  logic                            axis_clk,
    input  logic                            aresetn,
    input  logic                            wr_en_i,
    input  logic [parser_pkg::tbl_aw-1:0]   wr_addr_i,
    input  logic [parser_pkg::entry_w-1:0]  wr_data_i,
    input  logic [parser_pkg::tbl_aw-1:0]   rd_addr_i,
    output logic [parser_pkg::entry_w-1:0]  rd_data_o
);
    import parser_pkg::*;

    logic [entry_w-1:0] tbl_q [2**tbl_aw];

    always_ff @(posedge axis_clk or negedge aresetn) begin
        if (!aresetn) begin
            for (int i = 0; i < 2**tbl_aw; i++) begin
                tbl_q[i] <= '0;
            end
            rd_data_o <= '0;
        end else begin
            if (wr_en_i) begin
                tbl_q[wr_addr_i] <= wr_data_i;
            end
            // read sees the old entry on a same-cycle write
            rd_data_o <= tbl_q[rd_addr_i];
        end
    end

endmodule

//--- hdl/field_extract.sv
`timescale 1ns/1ps

module field_extract (
    input  logic                          axis_clk,
    input  logic                          aresetn,
    input  logic [parser_pkg::hdr_w-1:0]  hdr_i,
    input  logic [parser_pkg::act_w-1:0]  action_i,
    input  logic                          strobe_i,
    output logic [parser_pkg::val_w-1:0]  val_o,
    output logic [1:0]                    type_o,
    output logic [2:0]                    idx_o
);
    import parser_pkg::*;

    logic [hdr_w-1:0] shifted;
    logic [val_w-1:0] field;
    logic [1:0]       act_type;

    assign act_type = action_i[act_type_lsb +: 2];

    always_comb begin
        // bits past the end of the buffer shift in as zero
        shifted = hdr_i >> {action_i[act_off_lsb +: act_off_w], 3'b000};
        case (act_type)
            type_2b: field = {{(val_w - cont2_w){1'b0}}, shifted[cont2_w-1:0]};
            type_4b: field = {{(val_w - cont4_w){1'b0}}, shifted[cont4_w-1:0]};
            type_6b: field = shifted[val_w-1:0];
            default: field = '0;
        endcase
    end

    always_ff @(posedge axis_clk or negedge aresetn) begin
        if (!aresetn) begin
            val_o  <= '0;
            type_o <= type_none;
            idx_o  <= 3'd0;
        end else if (strobe_i) begin
            val_o  <= field;
            type_o <= act_type;
            idx_o  <= action_i[act_idx_lsb +: 3];
        end
    end

endmodule

//--- hdl/hdr_capture.sv
`timescale 1ns/1ps

module hdr_capture (
    input  logic                           axis_clk,
    input  logic                           aresetn,
    input  logic [parser_pkg::data_w-1:0]  s_axis_tdata_i,
    input  logic                           s_axis_tvalid_i,
    input  logic                           s_axis_tlast_i,
    output logic [parser_pkg::hdr_w-1:0]   hdr_o,
    output logic [parser_pkg::vlan_w-1:0]  vlan_id_o,
    output logic                           hdr_start_o
);
    import parser_pkg::*;

    logic tvalid_q;
    logic second_q;
    logic first_beat;

    // tvalid rising marks the first beat of a packet
    assign first_beat = s_axis_tvalid_i && !tvalid_q;

    always_ff @(posedge axis_clk or negedge aresetn) begin
        if (!aresetn) begin
            tvalid_q    <= 1'b0;
            second_q    <= 1'b0;
            hdr_start_o <= 1'b0;
        end else begin
            tvalid_q    <= s_axis_tvalid_i;
            hdr_start_o <= first_beat;
            // only the beat right after the first one is kept
            second_q    <= first_beat && !s_axis_tlast_i;
        end
    end

    always_ff @(posedge axis_clk or negedge aresetn) begin
        if (!aresetn) begin
            hdr_o     <= '0;
            vlan_id_o <= '0;
        end else begin
            if (first_beat) begin
                hdr_o[data_w-1:0] <= s_axis_tdata_i;
                vlan_id_o         <= s_axis_tdata_i[vlan_lsb +: vlan_w];
                // single-beat packet, nothing above the first beat
                if (s_axis_tlast_i) begin
                    hdr_o[hdr_w-1:data_w] <= '0;
                end
            end else if (second_q && s_axis_tvalid_i) begin
                hdr_o[hdr_w-1:data_w] <= s_axis_tdata_i;
            end
        end
    end

endmodule

//--- hdl/parser_pkg.sv
package parser_pkg;

    // stream and header buffer
    localparam int data_w = 512;
    localparam int hdr_w  = 2 * data_w;

    // parse-action table
    localparam int num_act = 10;
    localparam int act_w   = 16;
    localparam int entry_w = num_act * act_w;
    localparam int tbl_aw  = 4;

    // vlan id in the first beat
    localparam int vlan_w   = 12;
    localparam int vlan_lsb = 116;

    // fields of one parse action
    localparam int act_off_lsb  = 6;
    localparam int act_off_w    = 7;
    localparam int act_type_lsb = 4;
    localparam int act_idx_lsb  = 1;

    localparam logic [1:0] type_none = 2'b00;
    localparam logic [1:0] type_2b   = 2'b01;
    localparam logic [1:0] type_4b   = 2'b10;
    localparam logic [1:0] type_6b   = 2'b11;

    // containers
    localparam int cont2_w  = 16;
    localparam int cont4_w  = 32;
    localparam int cont6_w  = 48;
    localparam int val_w    = cont6_w;
    localparam int num_cont = 8;
    localparam int phv_w    = num_cont * (cont6_w + cont4_w + cont2_w) + vlan_w;

    // control packet layout
    localparam int          ctl_flag_lsb = 320;
    localparam logic [15:0] ctl_flag_val = 16'hf2f1;
    localparam int          ctl_mod_lsb  = 368;
    localparam int          ctl_idx_lsb  = 384;

    // state codes
    localparam logic [1:0] ps_idle  = 2'd0;
    localparam logic [1:0] ps_wait1 = 2'd1;
    localparam logic [1:0] ps_wait2 = 2'd2;
    localparam logic [1:0] ps_write = 2'd3;
    localparam logic [1:0] cs_idle  = 2'd0;
    localparam logic [1:0] cs_first = 2'd1;
    localparam logic [1:0] cs_next  = 2'd2;

endpackage
